/* rtl/vga_fb_cfg.svh */
`ifndef VGA_FB_CFG_SVH
`define VGA_FB_CFG_SVH

// Stored image, one byte per pixel
`define FB_RES_X 320
`define FB_RES_Y 240
`define FB_SCALE 2
// FB_RES_X * FB_RES_Y
`define FB_DEPTH 76800

// 640x480 at one pixel per VGA_CLK_DIV system clocks
`define VGA_H_TOTAL 800
`define VGA_V_TOTAL 525
`define VGA_H_SYNC 96
`define VGA_V_SYNC 2
`define VGA_H_START 144
`define VGA_H_END 784
`define VGA_V_START 35
`define VGA_V_END 515
`define VGA_CLK_DIV 2

`endif

/* rtl/vga_fb_pkg.sv */
package vga_fb_pkg;

    // One byte off the SPI link
    typedef logic [7:0] spi_byte_t;

    // Stored pixel, 0b00RRGGBB
    typedef logic [7:0] fb_pixel_t;

    // Covers FB_DEPTH entries
    typedef logic [16:0] fb_addr_t;

    // One VGA colour output
    typedef logic [3:0] vga_channel_t;

    // Screen counters
    typedef logic [9:0] h_count_t;
    typedef logic [9:0] v_count_t;

    // Control opcodes, taken from bits 6:0 of a byte with bit 7 set
    typedef enum logic [6:0] {
        CMD_ALIGN = 7'h00,
        CMD_SWAP  = 7'h01
    } fb_cmd_e;

endpackage

/* rtl/spi_byte_rx.sv */
module spi_byte_rx (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  sclk,
    input  logic                  cs_n,
    input  logic                  mosi,
    output logic                  rx_valid,
    output vga_fb_pkg::spi_byte_t rx_byte
);
    import vga_fb_pkg::*;

    spi_byte_t  shift_reg;
    logic [2:0] bit_cnt;
    spi_byte_t  captured;
    logic       ready_tgl;
    logic [2:0] tgl_sync;
    spi_byte_t  data_sync_0;
    spi_byte_t  data_sync_1;
    logic       byte_done;

    // ==========================================================
    // sclk domain
    // ==========================================================

    // Partial byte is dropped whenever cs_n goes high
    always_ff @(posedge sclk or posedge rst or posedge cs_n) begin
        if (rst || cs_n) begin
            shift_reg <= '0;
            bit_cnt   <= '0;
        end else begin
            shift_reg <= {shift_reg[6:0], mosi};
            bit_cnt   <= bit_cnt + 1'b1;
        end
    end

    // Eighth bit completes the byte
    assign byte_done = !cs_n && (bit_cnt == 3'd7);

    always_ff @(posedge sclk or posedge rst) begin
        if (rst) begin
            ready_tgl <= 1'b0;
        end else if (byte_done) begin
            ready_tgl <= ~ready_tgl;
        end
    end

    always_ff @(posedge sclk) begin
        if (byte_done) begin
            captured <= {shift_reg[6:0], mosi};
        end
    end

    // ==========================================================
    // clk domain
    // ==========================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tgl_sync <= '0;
            rx_valid <= 1'b0;
        end else begin
            tgl_sync <= {tgl_sync[1:0], ready_tgl};
            rx_valid <= tgl_sync[2] ^ tgl_sync[1];
        end
    end

    // Byte is held steady in sclk domain until the next one, so two flops do
    always_ff @(posedge clk) begin
        data_sync_0 <= captured;
        data_sync_1 <= data_sync_0;
        if (tgl_sync[2] ^ tgl_sync[1]) begin
            rx_byte <= data_sync_1;
        end
    end

endmodule

/* rtl/pixel_cmd_decoder.sv */
`include "vga_fb_cfg.svh"

module pixel_cmd_decoder (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rx_valid,
    input  vga_fb_pkg::spi_byte_t rx_byte,
    output logic                  wr_en,
    output logic                  swap_req,
    output vga_fb_pkg::fb_addr_t  wr_addr,
    output vga_fb_pkg::fb_pixel_t wr_data
);
    import vga_fb_pkg::*;

    fb_addr_t wr_ptr;
    fb_cmd_e  cmd;
    logic     is_pixel;

    assign is_pixel = !rx_byte[7];
    assign cmd      = fb_cmd_e'(rx_byte[6:0]);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr   <= '0;
            wr_en    <= 1'b0;
            swap_req <= 1'b0;
        end else begin
            wr_en    <= 1'b0;
            swap_req <= 1'b0;
            if (rx_valid && is_pixel) begin
                wr_en <= 1'b1;
                if (wr_ptr == `FB_DEPTH - 1) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end else if (rx_valid) begin
                case (cmd)
                    CMD_SWAP:  swap_req <= 1'b1;
                    CMD_ALIGN: wr_ptr   <= '0;
                    // Unknown opcodes behave as align
                    default:   wr_ptr   <= '0;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_valid && is_pixel) begin
            wr_addr <= wr_ptr;
            wr_data <= rx_byte;
        end
    end

endmodule

/* rtl/frame_ram.sv */
`include "vga_fb_cfg.svh"

module frame_ram (
    input  logic                  clk,
    input  logic                  wr_en,
    input  vga_fb_pkg::fb_addr_t  wr_addr,
    input  vga_fb_pkg::fb_addr_t  rd_addr,
    input  vga_fb_pkg::fb_pixel_t wr_data,
    output vga_fb_pkg::fb_pixel_t rd_data
);
    import vga_fb_pkg::*;

    fb_pixel_t mem [0:`FB_DEPTH-1];

    // Simple dual port, one write and one registered read
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* rtl/vga_timing.sv */
`include "vga_fb_cfg.svh"

module vga_timing (
    input  logic                 clk,
    input  logic                 rst,
    output logic                 h_sync,
    output logic                 v_sync,
    output logic                 active,
    output logic                 frame_start,
    output vga_fb_pkg::h_count_t pix_x,
    output vga_fb_pkg::v_count_t pix_y
);
    import vga_fb_pkg::*;

    localparam int DIV_W = $clog2(`VGA_CLK_DIV + 1);

    logic [DIV_W-1:0] div_cnt;
    logic             pix_en;
    h_count_t         h_count;
    v_count_t         v_count;
    logic             h_act;
    logic             v_act;

    // Pixel enable
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
        end else if (pix_en) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign pix_en = (div_cnt == `VGA_CLK_DIV - 1);

    // Line and frame counters
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            h_count <= '0;
            v_count <= '0;
        end else if (pix_en) begin
            if (h_count == `VGA_H_TOTAL - 1) begin
                h_count <= '0;
                if (v_count == `VGA_V_TOTAL - 1) begin
                    v_count <= '0;
                end else begin
                    v_count <= v_count + 1'b1;
                end
            end else begin
                h_count <= h_count + 1'b1;
            end
        end
    end

    // Syncs are active low and one clock behind, like the RAM read
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            h_sync <= 1'b1;
            v_sync <= 1'b1;
        end else begin
            h_sync <= (h_count >= `VGA_H_SYNC);
            v_sync <= (v_count >= `VGA_V_SYNC);
        end
    end

    assign h_act  = (h_count >= `VGA_H_START) && (h_count < `VGA_H_END);
    assign v_act  = (v_count >= `VGA_V_START) && (v_count < `VGA_V_END);
    assign active = h_act && v_act;

    // Coordinates within the visible window
    assign pix_x = active ? h_count_t'(h_count - `VGA_H_START) : '0;
    assign pix_y = active ? v_count_t'(v_count - `VGA_V_START) : '0;

    assign frame_start = (h_count == '0) && (v_count == '0);

endmodule

/* rtl/frame_swap_buffer.sv */
`include "vga_fb_cfg.svh"

module frame_swap_buffer (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     wr_en,
    input  logic                     swap_req,
    input  logic                     active,
    input  logic                     frame_start,
    input  vga_fb_pkg::fb_addr_t     wr_addr,
    input  vga_fb_pkg::fb_pixel_t    wr_data,
    input  vga_fb_pkg::h_count_t     pix_x,
    input  vga_fb_pkg::v_count_t     pix_y,
    output vga_fb_pkg::vga_channel_t vga_r,
    output vga_fb_pkg::vga_channel_t vga_g,
    output vga_fb_pkg::vga_channel_t vga_b
);
    import vga_fb_pkg::*;

    logic      curr_buffer;
    logic      swap_pending;
    logic      active_q;
    logic      wr_en_0;
    logic      wr_en_1;
    fb_addr_t  rd_addr;
    fb_pixel_t rd_data_0;
    fb_pixel_t rd_data_1;
    fb_pixel_t pixel;

    // ==========================================================
    // Buffer select
    // ==========================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            curr_buffer  <= 1'b0;
            swap_pending <= 1'b0;
        end else if (frame_start && swap_pending) begin
            curr_buffer  <= ~curr_buffer;
            // A request in the same clock waits for the next frame
            swap_pending <= swap_req;
        end else if (swap_req) begin
            swap_pending <= 1'b1;
        end
    end

    // Writes go to curr_buffer, display reads the other one
    assign wr_en_0 = wr_en && !curr_buffer;
    assign wr_en_1 = wr_en && curr_buffer;

    // Each stored pixel covers FB_SCALE x FB_SCALE screen pixels
    assign rd_addr = fb_addr_t'((pix_x / `FB_SCALE) + (pix_y / `FB_SCALE) * `FB_RES_X);

    frame_ram ram_0 (
        .clk     (clk),
        .wr_en   (wr_en_0),
        .wr_addr (wr_addr),
        .rd_addr (rd_addr),
        .wr_data (wr_data),
        .rd_data (rd_data_0)
    );

    frame_ram ram_1 (
        .clk     (clk),
        .wr_en   (wr_en_1),
        .wr_addr (wr_addr),
        .rd_addr (rd_addr),
        .wr_data (wr_data),
        .rd_data (rd_data_1)
    );

    // ==========================================================
    // Colour output
    // ==========================================================

    // Matches the one clock read latency
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active_q <= 1'b0;
        end else begin
            active_q <= active;
        end
    end

    assign pixel = curr_buffer ? rd_data_0 : rd_data_1;

    // 2 bit fields widened with zero LSBs
    assign vga_r = active_q ? {pixel[5:4], 2'b00} : '0;
    assign vga_g = active_q ? {pixel[3:2], 2'b00} : '0;
    assign vga_b = active_q ? {pixel[1:0], 2'b00} : '0;

endmodule

/* rtl/vga_spi_fb.sv */
module vga_spi_fb (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     sclk,
    input  logic                     cs_n,
    input  logic                     mosi,
    output vga_fb_pkg::vga_channel_t vga_r,
    output vga_fb_pkg::vga_channel_t vga_g,
    output vga_fb_pkg::vga_channel_t vga_b,
    output logic                     h_sync,
    output logic                     v_sync
);
    import vga_fb_pkg::*;

    logic      rx_valid;
    spi_byte_t rx_byte;
    logic      wr_en;
    logic      swap_req;
    fb_addr_t  wr_addr;
    fb_pixel_t wr_data;
    logic      active;
    logic      frame_start;
    h_count_t  pix_x;
    v_count_t  pix_y;

    spi_byte_rx u_rx (
        .clk      (clk),
        .rst      (rst),
        .sclk     (sclk),
        .cs_n     (cs_n),
        .mosi     (mosi),
        .rx_valid (rx_valid),
        .rx_byte  (rx_byte)
    );

    pixel_cmd_decoder u_dec (
        .clk      (clk),
        .rst      (rst),
        .rx_valid (rx_valid),
        .rx_byte  (rx_byte),
        .wr_en    (wr_en),
        .swap_req (swap_req),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

    vga_timing u_timing (
        .clk         (clk),
        .rst         (rst),
        .h_sync      (h_sync),
        .v_sync      (v_sync),
        .active      (active),
        .frame_start (frame_start),
        .pix_x       (pix_x),
        .pix_y       (pix_y)
    );

    frame_swap_buffer u_fb (
        .clk         (clk),
        .rst         (rst),
        .wr_en       (wr_en),
        .swap_req    (swap_req),
        .active      (active),
        .frame_start (frame_start),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .pix_x       (pix_x),
        .pix_y       (pix_y),
        .vga_r       (vga_r),
        .vga_g       (vga_g),
        .vga_b       (vga_b)
    );

endmodule

/* test/tb_vga_spi_fb.sv */
`include "vga_fb_cfg.svh"

module tb_vga_spi_fb;
    import vga_fb_pkg::*;

    localparam int LINE_CLK = `VGA_H_TOTAL * `VGA_CLK_DIV;
    localparam int FRAME_CLK = LINE_CLK * `VGA_V_TOTAL;
    // Six frames plus ten percent
    localparam int TIMEOUT_CYCLES = FRAME_CLK * 66 / 10;
    localparam int SCLK_HALF = 4;
    localparam int SETTLE_CLK = 8;
    localparam int MAX_ERR_LINES = 20;
    // Clocks of scan-out per stored pixel
    localparam int CLK_PER_PIXEL = `FB_SCALE * `FB_SCALE * `VGA_CLK_DIV;

    logic         clk;
    logic         rst;
    logic         sclk;
    logic         cs_n;
    logic         mosi;
    vga_channel_t vga_r;
    vga_channel_t vga_g;
    vga_channel_t vga_b;
    logic         h_sync;
    logic         v_sync;

    // Reference model of both buffers
    fb_pixel_t model_mem [0:1][0:`FB_DEPTH-1];
    bit        model_wr  [0:1][0:`FB_DEPTH-1];
    int        model_ptr;
    bit        model_wbuf;
    bit        model_swap_pend;

    bit        locked;
    logic      v_sync_prev;
    int        pos;
    int        frame_cnt;
    int        err_count;
    int        pix_checks;
    int        cycle_cnt;
    int        tests_run;
    int        tests_failed;
    integer    seed;

    vga_spi_fb dut (
        .clk    (clk),
        .rst    (rst),
        .sclk   (sclk),
        .cs_n   (cs_n),
        .mosi   (mosi),
        .vga_r  (vga_r),
        .vga_g  (vga_g),
        .vga_b  (vga_b),
        .h_sync (h_sync),
        .v_sync (v_sync)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d clock cycles, the test sequence did not finish",
                     cycle_cnt);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // ============================================================
    // Compare tasks
    // ============================================================
    task automatic check_channel(input string name, input vga_channel_t exp,
                                 input vga_channel_t act);
        if (act !== exp) begin
            err_count++;
            if (err_count <= MAX_ERR_LINES) begin
                $display("ERROR %s expected %h actual %h at frame clock %0d",
                         name, exp, act, pos);
            end
        end
    endtask

    task automatic check_sync(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            err_count++;
            if (err_count <= MAX_ERR_LINES) begin
                $display("ERROR %s expected %h actual %h at frame clock %0d",
                         name, exp, act, pos);
            end
        end
    endtask

    // Screen must not show a pixel that only the write buffer holds
    task automatic check_hidden(input int addr, input fb_pixel_t px);
        vga_channel_t r;
        vga_channel_t g;
        vga_channel_t b;
        r = {px[5:4], 2'b00};
        g = {px[3:2], 2'b00};
        b = {px[1:0], 2'b00};
        // Black cannot be told apart from cleared memory
        if (px != 8'h00 && vga_r === r && vga_g === g && vga_b === b) begin
            err_count++;
            if (err_count <= MAX_ERR_LINES) begin
                $display("Write buffer pixel at address %0d is on screen at frame clock %0d",
                         addr, pos);
            end
        end
    endtask

    // ============================================================
    // Scan-out checker
    // ============================================================
    task automatic check_scan();
        int        line;
        int        col;
        int        hc;
        int        addr;
        bit        disp;
        fb_pixel_t px;
        line = pos / LINE_CLK;
        col  = pos % LINE_CLK;
        hc   = col / `VGA_CLK_DIV;
        disp = ~model_wbuf;
        check_sync("h_sync", (col >= `VGA_H_SYNC * `VGA_CLK_DIV) ? 1'b1 : 1'b0, h_sync);
        check_sync("v_sync", (line >= `VGA_V_SYNC) ? 1'b1 : 1'b0, v_sync);
        if (hc >= `VGA_H_START && hc < `VGA_H_END &&
            line >= `VGA_V_START && line < `VGA_V_END) begin
            addr = (hc - `VGA_H_START) / `FB_SCALE +
                   ((line - `VGA_V_START) / `FB_SCALE) * `FB_RES_X;
            // Unwritten entries hold no known value
            if (model_wr[disp][addr]) begin
                px = model_mem[disp][addr];
                pix_checks++;
                check_channel("vga_r", {px[5:4], 2'b00}, vga_r);
                check_channel("vga_g", {px[3:2], 2'b00}, vga_g);
                check_channel("vga_b", {px[1:0], 2'b00}, vga_b);
            end else if (model_wr[model_wbuf][addr]) begin
                check_hidden(addr, model_mem[model_wbuf][addr]);
            end
        end else begin
            check_channel("vga_r", 4'h0, vga_r);
            check_channel("vga_g", 4'h0, vga_g);
            check_channel("vga_b", 4'h0, vga_b);
        end
    endtask

    // Outputs are sampled on the falling clock edge
    always @(negedge clk) begin
        bit fall;
        fall = (v_sync_prev === 1'b1) && (v_sync === 1'b0);
        if (!rst) begin
            if (fall) begin
                frame_cnt++;
                if (model_swap_pend) begin
                    model_wbuf      = ~model_wbuf;
                    model_swap_pend = 1'b0;
                end
            end
            if (locked) begin
                pos = (pos + 1) % FRAME_CLK;
            end else if (fall) begin
                locked = 1'b1;
                pos    = 0;
            end
            if (locked) begin
                check_scan();
            end
        end
        v_sync_prev = v_sync;
    end

    // ============================================================
    // Stimulus
    // ============================================================
    task automatic tick(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic wait_frame();
        int start;
        start = frame_cnt;
        while (frame_cnt == start) @(posedge clk);
        #1;
    endtask

    task automatic wait_line(input int line);
        while (pos < line * LINE_CLK) @(posedge clk);
        #1;
    endtask

    // MSB first, one byte per chip select
    task automatic spi_send(input spi_byte_t b);
        cs_n = 1'b0;
        tick(1);
        for (int i = 7; i >= 0; i--) begin
            mosi = b[i];
            sclk = 1'b0;
            tick(SCLK_HALF);
            sclk = 1'b1;
            tick(SCLK_HALF);
        end
        sclk = 1'b0;
        cs_n = 1'b1;
        mosi = 1'b0;
        tick(SETTLE_CLK);
    endtask

    task automatic model_byte(input spi_byte_t b);
        if (!b[7]) begin
            model_mem[model_wbuf][model_ptr] = b;
            model_wr[model_wbuf][model_ptr]  = 1'b1;
            model_ptr = (model_ptr == `FB_DEPTH - 1) ? 0 : model_ptr + 1;
        end else if (b == 8'h81) begin
            model_swap_pend = 1'b1;
        end else begin
            model_ptr = 0;
        end
    endtask

    task automatic send_byte(input spi_byte_t b);
        spi_send(b);
        model_byte(b);
    endtask

    task automatic send_pixels(input int n);
        int rnd;
        for (int i = 0; i < n; i++) begin
            rnd = $random(seed);
            send_byte(spi_byte_t'(rnd & 32'h3f));
        end
    endtask

    task automatic finish_test(input string name, input int err_start,
                               input int chk_start, input int exp_checks);
        int errs;
        errs = err_count - err_start;
        tests_run++;
        if (pix_checks - chk_start != exp_checks) begin
            $display("%s: %0d known pixel clocks were expected on screen but %0d were seen",
                     name, exp_checks, pix_checks - chk_start);
            errs++;
        end
        if (errs == 0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errs);
        end
    endtask

    initial begin
        int err_start;
        int chk_start;
        seed            = 32'hc0c0_e6e3;
        rst             = 1'b1;
        sclk            = 1'b0;
        cs_n            = 1'b1;
        mosi            = 1'b0;
        model_ptr       = 0;
        model_wbuf      = 1'b0;
        model_swap_pend = 1'b0;
        locked          = 1'b0;
        v_sync_prev     = 1'b1;
        pos             = 0;
        frame_cnt       = 0;
        err_count       = 0;
        pix_checks      = 0;
        cycle_cnt       = 0;
        tests_run       = 0;
        tests_failed    = 0;
        tick(2);
        rst = 1'b0;

        // Lock onto the first v_sync fall, then one whole frame
        err_start = err_count;
        chk_start = pix_checks;
        wait_frame();
        wait_frame();
        finish_test("sync timing", err_start, chk_start, 0);

        err_start = err_count;
        chk_start = pix_checks;
        send_pixels(640);
        wait_frame();
        finish_test("back buffer hidden", err_start, chk_start, 0);

        // Swap mid-frame so rows 0 and 1 appear on lines 35 to 38 of the next frame
        err_start = err_count;
        chk_start = pix_checks;
        wait_line(300);
        send_byte(8'h81);
        wait_frame();
        wait_line(45);
        finish_test("swap and scan-out", err_start, chk_start, 640 * CLK_PER_PIXEL);

        // Pointer continues at 640 until the align
        err_start = err_count;
        chk_start = pix_checks;
        send_pixels(16);
        send_byte(8'h80);
        send_pixels(320);
        wait_line(300);
        send_byte(8'h81);
        wait_frame();
        wait_line(45);
        finish_test("align", err_start, chk_start, 336 * CLK_PER_PIXEL);

        // Old image stays up a whole frame, then a swap shows the new pixels at 0 to 31
        err_start = err_count;
        chk_start = pix_checks;
        send_byte(8'h85);
        send_pixels(32);
        wait_frame();
        wait_line(300);
        send_byte(8'h81);
        wait_frame();
        wait_line(45);
        finish_test("unknown control byte", err_start, chk_start,
                    (336 + 640) * CLK_PER_PIXEL);

        $display("tests run %0d, tests failed %0d, value errors %0d",
                 tests_run, tests_failed, err_count);
        if (tests_failed == 0 && err_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+rtl
rtl/vga_fb_pkg.sv
rtl/spi_byte_rx.sv
rtl/pixel_cmd_decoder.sv
rtl/frame_ram.sv
rtl/vga_timing.sv
rtl/frame_swap_buffer.sv
rtl/vga_spi_fb.sv
test/tb_vga_spi_fb.sv
